//--- mul_share_pkg.sv
/* shared multiply engine definitions
   operand and product widths, pipeline latency and client id */
package mul_share_pkg;

	// ------------------------------
	// datapath widths
	// ------------------------------
	localparam int operand_w = 30;
	localparam int product_w = 60;

	// accumulator wraps at this width
	localparam int acc_w = 64;

	// ------------------------------
	// multiplier and clients
	// ------------------------------

	// edges from sampled start to stop
	localparam int mul_latency = 5;

	localparam int num_clients = 2;

	// tag carried through the multiplier
	typedef logic [$clog2(num_clients)-1:0] client_id_t;

endpackage

//--- mul_req_if.sv
/* one client's link to the shared multiplier
   request with operands out, grant and tagged product back */
interface mul_req_if;

	// client side
	logic req;
	logic [mul_share_pkg::operand_w-1:0] a;
	logic [mul_share_pkg::operand_w-1:0] b;

	// arbiter side
	logic grant;
	logic rsp_valid;
	logic [mul_share_pkg::product_w-1:0] product;

	modport client (
		output req,
		output a,
		output b,
		input  grant,
		input  rsp_valid,
		input  product
	);

	modport arbiter (
		input  req,
		input  a,
		input  b,
		output grant,
		output rsp_valid,
		output product
	);

endinterface

//--- mul_array.sv
/* pipelined 30x30 unsigned multiplier
   2-bit partial products and a four level adder tree, tag follows each product */
module mul_array #(
	parameter type tag_t = logic
) (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic [mul_share_pkg::operand_w-1:0] a,
	input  logic [mul_share_pkg::operand_w-1:0] b,
	input  tag_t tag_in,
	output logic stop,
	output logic [mul_share_pkg::product_w-1:0] out,
	output tag_t tag_out
);

	// widths grow by the shift of each adder level
	typedef logic [mul_share_pkg::operand_w+1:0] pp_t;
	typedef logic [mul_share_pkg::operand_w+3:0] s2_t;
	typedef logic [mul_share_pkg::operand_w+7:0] s3_t;
	typedef logic [mul_share_pkg::operand_w+15:0] s4_t;
	typedef logic [mul_share_pkg::product_w-1:0] s5_t;

	// one valid bit per stage
	logic [5:1] vld;
	tag_t tag_q [5:1];

	pp_t pp [15];
	s2_t s2 [8];
	s3_t s3 [4];
	s4_t s4 [2];
	s5_t s5;

	// a times two bits of b
	function automatic pp_t part_prod(
		input logic [mul_share_pkg::operand_w-1:0] x,
		input logic [1:0] bits
	);
		pp_t p;
		case (bits)
			2'd0: p = '0;
			2'd1: p = pp_t'(x);
			2'd2: p = pp_t'(x) << 1;
			default: p = pp_t'(x) + (pp_t'(x) << 1);
		endcase
		return p;
	endfunction

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			vld <= '0;
			stop <= 1'b0;
		end else begin
			vld <= {vld[4:1], start};
			stop <= vld[5];
		end
	end

	// ------------------------------
	// stage 1: partial products
	// ------------------------------
	always_ff @(posedge clk) begin
		if (start) begin
			for (int i = 0; i < 15; i++)
				pp[i] <= part_prod(a, b[2*i +: 2]);
			tag_q[1] <= tag_in;
		end
	end

	// stage 2, pairs shifted by 2
	always_ff @(posedge clk) begin
		if (vld[1]) begin
			for (int i = 0; i < 7; i++)
				s2[i] <= s2_t'(pp[2*i]) + (s2_t'(pp[2*i+1]) << 2);
			// odd one out, top two bits of b
			s2[7] <= s2_t'(pp[14]);
			tag_q[2] <= tag_q[1];
		end
	end

	// stage 3, shift by 4
	always_ff @(posedge clk) begin
		if (vld[2]) begin
			for (int i = 0; i < 4; i++)
				s3[i] <= s3_t'(s2[2*i]) + (s3_t'(s2[2*i+1]) << 4);
			tag_q[3] <= tag_q[2];
		end
	end

	// stage 4, shift by 8
	always_ff @(posedge clk) begin
		if (vld[3]) begin
			for (int i = 0; i < 2; i++)
				s4[i] <= s4_t'(s3[2*i]) + (s4_t'(s3[2*i+1]) << 8);
			tag_q[4] <= tag_q[3];
		end
	end

	// stage 5, final sum fits product_w exactly
	always_ff @(posedge clk) begin
		if (vld[4]) begin
			s5 <= s5_t'(s4[0]) + (s5_t'(s4[1]) << 16);
			tag_q[5] <= tag_q[4];
		end
	end

	// ------------------------------
	// result register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (vld[5]) begin
			out <= s5;
			tag_out <= tag_q[5];
		end
	end

	// fixed latency, products never merge or vanish in flight
	// stop rises on the mul_latency-th edge, so it is sampled one edge later
	property p_start_to_stop;
		@(posedge clk) disable iff (rst)
			start |-> ##(mul_share_pkg::mul_latency + 1) stop;
	endproperty

	property p_stop_from_start;
		@(posedge clk) disable iff (rst)
			stop |-> $past(start, mul_share_pkg::mul_latency + 1);
	endproperty

	a_start_to_stop: assert property (p_start_to_stop)
		else $error("stop missing %0d cycles after start", mul_share_pkg::mul_latency);
	a_stop_from_start: assert property (p_stop_from_start)
		else $error("stop without a start %0d cycles earlier", mul_share_pkg::mul_latency);

endmodule

//--- mul_arbiter.sv
/* round-robin arbiter for the shared multiplier
   grants one client per cycle and steers each product back by its tag */
module mul_arbiter (
	input  logic clk,
	input  logic rst,
	mul_req_if.arbiter c0,
	mul_req_if.arbiter c1,
	output logic start,
	output logic [mul_share_pkg::operand_w-1:0] a,
	output logic [mul_share_pkg::operand_w-1:0] b,
	output mul_share_pkg::client_id_t tag,
	input  logic stop,
	input  logic [mul_share_pkg::product_w-1:0] out,
	input  mul_share_pkg::client_id_t tag_out
);

	mul_share_pkg::client_id_t last_grant;
	logic grant_0;
	logic grant_1;

	// ------------------------------
	// grant
	// ------------------------------

	// on contention the client not served last wins
	always_comb begin
		grant_0 = c0.req && (!c1.req || last_grant == mul_share_pkg::client_id_t'(1));
		grant_1 = c1.req && (!c0.req || last_grant == mul_share_pkg::client_id_t'(0));
	end

	always_ff @(posedge clk) begin
		if (rst)
			last_grant <= '0;
		else if (start)
			last_grant <= tag;
	end

	assign c0.grant = grant_0;
	assign c1.grant = grant_1;

	// operands of the winner into the multiplier
	assign start = grant_0 || grant_1;
	assign a = grant_1 ? c1.a : c0.a;
	assign b = grant_1 ? c1.b : c0.b;
	assign tag = mul_share_pkg::client_id_t'(grant_1);

	// ------------------------------
	// response routing
	// ------------------------------
	assign c0.rsp_valid = stop && (tag_out == mul_share_pkg::client_id_t'(0));
	assign c1.rsp_valid = stop && (tag_out == mul_share_pkg::client_id_t'(1));
	assign c0.product = out;
	assign c1.product = out;

	property p_grant_onehot;
		@(posedge clk) disable iff (rst)
			$onehot0({c0.grant, c1.grant});
	endproperty

	property p_grant_needs_req;
		@(posedge clk) disable iff (rst)
			(c0.grant |-> c0.req) and (c1.grant |-> c1.req);
	endproperty

	a_grant_onehot: assert property (p_grant_onehot)
		else $error("both clients granted in one cycle");
	a_grant_needs_req: assert property (p_grant_needs_req)
		else $error("grant to a client with no request");

endmodule

//--- mac_client.sv
/* multiply-accumulate client
   holds one operand pair, waits for the shared multiplier, adds the product */
module mac_client (
	input  logic clk,
	input  logic rst,
	input  logic load,
	input  logic clear,
	input  logic [mul_share_pkg::operand_w-1:0] a_in,
	input  logic [mul_share_pkg::operand_w-1:0] b_in,
	output logic busy,
	output logic done,
	output logic [mul_share_pkg::acc_w-1:0] acc,
	mul_req_if.client port
);

	logic pending;
	logic [mul_share_pkg::operand_w-1:0] a_q;
	logic [mul_share_pkg::operand_w-1:0] b_q;

	// ------------------------------
	// request
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			pending <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= port.rsp_valid;
			if (port.grant)
				pending <= 1'b0;
			if (port.rsp_valid)
				busy <= 1'b0;
			// loads while busy are dropped
			if (load && !busy) begin
				busy <= 1'b1;
				pending <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load && !busy) begin
			a_q <= a_in;
			b_q <= b_in;
		end
	end

	assign port.req = pending;
	assign port.a = a_q;
	assign port.b = b_q;

	// ------------------------------
	// accumulate
	// ------------------------------

	// wraps at acc_w, clear restarts from zero
	always_ff @(posedge clk) begin
		if (rst)
			acc <= '0;
		else if (clear || port.rsp_valid)
			acc <= (clear ? '0 : acc)
				+ (port.rsp_valid ? mul_share_pkg::acc_w'(port.product) : '0);
	end

	// a product only returns to a client that asked for one
	property p_rsp_while_busy;
		@(posedge clk) disable iff (rst)
			port.rsp_valid |-> busy;
	endproperty

	a_rsp_while_busy: assert property (p_rsp_while_busy)
		else $error("product returned to an idle client");

endmodule

//--- mul_share_top.sv
/* shared multiply engine
   two accumulating clients share one pipelined multiplier */
module mul_share_top (
	input  logic clk,
	input  logic rst,

	input  logic load_0,
	input  logic clear_0,
	input  logic [mul_share_pkg::operand_w-1:0] a_0,
	input  logic [mul_share_pkg::operand_w-1:0] b_0,
	output logic busy_0,
	output logic done_0,
	output logic [mul_share_pkg::acc_w-1:0] acc_0,

	input  logic load_1,
	input  logic clear_1,
	input  logic [mul_share_pkg::operand_w-1:0] a_1,
	input  logic [mul_share_pkg::operand_w-1:0] b_1,
	output logic busy_1,
	output logic done_1,
	output logic [mul_share_pkg::acc_w-1:0] acc_1
);

	mul_req_if c0_if ();
	mul_req_if c1_if ();

	// multiplier side of the arbiter
	logic mul_start;
	logic [mul_share_pkg::operand_w-1:0] mul_a;
	logic [mul_share_pkg::operand_w-1:0] mul_b;
	mul_share_pkg::client_id_t mul_tag;
	logic mul_stop;
	logic [mul_share_pkg::product_w-1:0] mul_out;
	mul_share_pkg::client_id_t mul_tag_out;

	// ------------------------------
	// clients
	// ------------------------------
	mac_client client_0_i (
		.clk   (clk),
		.rst   (rst),
		.load  (load_0),
		.clear (clear_0),
		.a_in  (a_0),
		.b_in  (b_0),
		.busy  (busy_0),
		.done  (done_0),
		.acc   (acc_0),
		.port  (c0_if.client)
	);

	mac_client client_1_i (
		.clk   (clk),
		.rst   (rst),
		.load  (load_1),
		.clear (clear_1),
		.a_in  (a_1),
		.b_in  (b_1),
		.busy  (busy_1),
		.done  (done_1),
		.acc   (acc_1),
		.port  (c1_if.client)
	);

	// ------------------------------
	// arbiter and multiplier
	// ------------------------------
	mul_arbiter arbiter_i (
		.clk     (clk),
		.rst     (rst),
		.c0      (c0_if.arbiter),
		.c1      (c1_if.arbiter),
		.start   (mul_start),
		.a       (mul_a),
		.b       (mul_b),
		.tag     (mul_tag),
		.stop    (mul_stop),
		.out     (mul_out),
		.tag_out (mul_tag_out)
	);

	mul_array #(
		.tag_t (mul_share_pkg::client_id_t)
	) mul_array_i (
		.clk     (clk),
		.rst     (rst),
		.start   (mul_start),
		.a       (mul_a),
		.b       (mul_b),
		.tag_in  (mul_tag),
		.stop    (mul_stop),
		.out     (mul_out),
		.tag_out (mul_tag_out)
	);

endmodule

//--- tb_mul_share.sv
/* testbench for the shared multiply engine
   solo, contended and back to back loads on both clients, checked by assertions */
module tb_mul_share;
	timeunit 1ns;
	timeprecision 100ps;

	// solo 10, contended 8, chained 100, clear and busy 4
	localparam int n_loads = 10 + 8 + 100 + 4;
	localparam int cycle_limit = 40 * n_loads + 200;
	// load edge to done edge is seven cycles, seen one sample later
	localparam int done_lat = 8;
	localparam int chain_len = 50;

	logic clk = 1'b0;
	logic rst;

	logic load_0;
	logic clear_0;
	logic [mul_share_pkg::operand_w-1:0] a_0;
	logic [mul_share_pkg::operand_w-1:0] b_0;
	logic busy_0;
	logic done_0;
	logic [mul_share_pkg::acc_w-1:0] acc_0;

	logic load_1;
	logic clear_1;
	logic [mul_share_pkg::operand_w-1:0] a_1;
	logic [mul_share_pkg::operand_w-1:0] b_1;
	logic busy_1;
	logic done_1;
	logic [mul_share_pkg::acc_w-1:0] acc_1;

	logic accept_0;
	logic accept_1;
	logic solo;
	logic [mul_share_pkg::acc_w-1:0] model_acc [2];
	logic [mul_share_pkg::operand_w-1:0] chain_a [2][chain_len];
	logic [mul_share_pkg::operand_w-1:0] chain_b [2][chain_len];
	logic [31:0] seed = 32'h6140_f201;
	int cycles = 0;
	int n_value = 0;
	int n_timing = 0;

	mul_share_top mul_share_top_i (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic logic [mul_share_pkg::operand_w-1:0] rand_operand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:2];
	endfunction

	task automatic value_error(input string msg);
		n_value++;
		$display("[FAIL] t=%0d ns %s", $time, msg);
	endtask

	task automatic timing_error(input string msg);
		n_timing++;
		$display("[FAIL] t=%0d ns %s", $time, msg);
	endtask

	// one cycle of load and clear, model follows what the client should accept
	task automatic drive_op(input int c, input logic do_load, input logic do_clear,
			input logic [mul_share_pkg::operand_w-1:0] a,
			input logic [mul_share_pkg::operand_w-1:0] b, input logic counted);
		logic [mul_share_pkg::acc_w-1:0] prod;
		prod = mul_share_pkg::acc_w'(a) * mul_share_pkg::acc_w'(b);
		@(posedge clk);
		if (c == 0) begin
			load_0 <= do_load;
			clear_0 <= do_clear;
			a_0 <= a;
			b_0 <= b;
		end else begin
			load_1 <= do_load;
			clear_1 <= do_clear;
			a_1 <= a;
			b_1 <= b;
		end
		if (do_clear)
			model_acc[c] = '0;
		if (counted)
			model_acc[c] = model_acc[c] + prod;
		@(posedge clk);
		if (c == 0) begin
			load_0 <= 1'b0;
			clear_0 <= 1'b0;
		end else begin
			load_1 <= 1'b0;
			clear_1 <= 1'b0;
		end
	endtask

	task automatic wait_done(input int c);
		do
			@(negedge clk);
		while (!(c == 0 ? done_0 : done_1));
	endtask

	task automatic run_solo(input int c, input logic [mul_share_pkg::operand_w-1:0] a,
			input logic [mul_share_pkg::operand_w-1:0] b);
		drive_op(c, 1'b1, 1'b0, a, b, 1'b1);
		wait_done(c);
	endtask

	// next load goes out as soon as done is seen
	task automatic run_chain(input int c);
		for (int i = 0; i < chain_len; i++) begin
			drive_op(c, 1'b1, 1'b0, chain_a[c][i], chain_b[c][i], 1'b1);
			wait_done(c);
		end
	endtask

	// ------------------------------
	// checks
	// ------------------------------
	assign accept_0 = load_0 && !busy_0;
	assign accept_1 = load_1 && !busy_1;

	a_reset_0: assert property (@(posedge clk) $fell(rst) |-> !busy_0 && !done_0 && acc_0 == '0)
		else value_error("client 0 not idle after reset");
	a_reset_1: assert property (@(posedge clk) $fell(rst) |-> !busy_1 && !done_1 && acc_1 == '0)
		else value_error("client 1 not idle after reset");

	a_solo_lat_0: assert property (@(posedge clk) disable iff (rst)
			solo && accept_0 |-> ##(done_lat) done_0)
		else timing_error("client 0 uncontended done not 7 cycles after load");
	a_solo_lat_1: assert property (@(posedge clk) disable iff (rst)
			solo && accept_1 |-> ##(done_lat) done_1)
		else timing_error("client 1 uncontended done not 7 cycles after load");

	a_bound_0: assert property (@(posedge clk) disable iff (rst)
			$past(accept_0, done_lat + 1) |-> done_0 || $past(done_0))
		else timing_error("client 0 done later than 8 cycles after load");
	a_bound_1: assert property (@(posedge clk) disable iff (rst)
			$past(accept_1, done_lat + 1) |-> done_1 || $past(done_1))
		else timing_error("client 1 done later than 8 cycles after load");

	a_no_stray_0: assert property (@(posedge clk) disable iff (rst)
			done_0 |-> $past(accept_0, done_lat) || $past(accept_0, done_lat + 1))
		else timing_error("client 0 done without a matching load");
	a_no_stray_1: assert property (@(posedge clk) disable iff (rst)
			done_1 |-> $past(accept_1, done_lat) || $past(accept_1, done_lat + 1))
		else timing_error("client 1 done without a matching load");

	a_acc_0: assert property (@(posedge clk) disable iff (rst) done_0 |-> acc_0 == model_acc[0])
		else value_error("client 0 acc differs from model");
	a_acc_1: assert property (@(posedge clk) disable iff (rst) done_1 |-> acc_1 == model_acc[1])
		else value_error("client 1 acc differs from model");

	a_clear_0: assert property (@(posedge clk) disable iff (rst) clear_0 |=> acc_0 == '0)
		else value_error("client 0 acc not zero after clear");
	a_clear_1: assert property (@(posedge clk) disable iff (rst) clear_1 |=> acc_1 == '0)
		else value_error("client 1 acc not zero after clear");

	a_busy_load_0: assert property (@(posedge clk) disable iff (rst)
			load_0 && busy_0 |=> acc_0 == $past(acc_0) || done_0)
		else value_error("client 0 acc changed by a load while busy");
	a_busy_load_1: assert property (@(posedge clk) disable iff (rst)
			load_1 && busy_1 |=> acc_1 == $past(acc_1) || done_1)
		else value_error("client 1 acc changed by a load while busy");

	// one product per cycle leaves the multiplier
	a_done_apart: assert property (@(posedge clk) disable iff (rst) !(done_0 && done_1))
		else timing_error("both clients done in the same cycle");

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin
		logic [mul_share_pkg::operand_w-1:0] x0;
		logic [mul_share_pkg::operand_w-1:0] y0;
		logic [mul_share_pkg::operand_w-1:0] x1;
		logic [mul_share_pkg::operand_w-1:0] y1;
		rst = 1'b1;
		load_0 = 1'b0;
		clear_0 = 1'b0;
		a_0 = '0;
		b_0 = '0;
		load_1 = 1'b0;
		clear_1 = 1'b0;
		a_1 = '0;
		b_1 = '0;
		solo = 1'b0;
		model_acc[0] = '0;
		model_acc[1] = '0;
		// high operands so the chained sums wrap the accumulator
		for (int c = 0; c < 2; c++)
			for (int i = 0; i < chain_len; i++) begin
				chain_a[c][i] = rand_operand() | 30'h3800_0000;
				chain_b[c][i] = rand_operand() | 30'h3800_0000;
			end
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		solo = 1'b1;
		for (int c = 0; c < 2; c++) begin
			run_solo(c, '0, rand_operand());
			run_solo(c, rand_operand(), '0);
			run_solo(c, '1, '1);
			repeat (2) run_solo(c, rand_operand(), rand_operand());
		end

		// both clients load in the same cycle
		solo = 1'b0;
		repeat (4) begin
			x0 = rand_operand();
			y0 = rand_operand();
			x1 = rand_operand();
			y1 = rand_operand();
			fork
				drive_op(0, 1'b1, 1'b0, x0, y0, 1'b1);
				drive_op(1, 1'b1, 1'b0, x1, y1, 1'b1);
			join
			fork
				wait_done(0);
				wait_done(1);
			join
		end

		fork
			run_chain(0);
			run_chain(1);
		join

		// clear on idle, then a load that lands while busy
		solo = 1'b1;
		drive_op(0, 1'b0, 1'b1, '0, '0, 1'b0);
		drive_op(0, 1'b1, 1'b0, rand_operand(), rand_operand(), 1'b1);
		drive_op(0, 1'b1, 1'b0, rand_operand(), rand_operand(), 1'b0);
		wait_done(0);
		drive_op(1, 1'b1, 1'b1, rand_operand(), rand_operand(), 1'b1);
		drive_op(1, 1'b1, 1'b0, rand_operand(), rand_operand(), 1'b0);
		wait_done(1);

		repeat (10) @(posedge clk);
		$display("errors: %0d value, %0d timing", n_value, n_timing);
		if (n_value == 0 && n_timing == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- mul_share_top.f
mul_share_pkg.sv
mul_req_if.sv
mul_array.sv
mul_arbiter.sv
mac_client.sv
mul_share_top.sv
tb_mul_share.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the shared multiply engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mul_share -f mul_share_top.f --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_mul_share > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "STATUS: PASS" "$log"; then
	exit 0
fi
exit 1
